// File: rtl/mips_cfg.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core widths, reset pc, opcode and funct codes
// alu and load select codes, syscall exit code
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

`define MIPS_XLEN        32
`define MIPS_TEXT_START  32'h00400000
`define MIPS_SYS_EXIT    32'd10        // $v0 value that ends the program
`define MIPS_REG_RA      5'd31

// primary opcodes
`define MIPS_OP_SPECIAL  6'h00
`define MIPS_OP_J        6'h02
`define MIPS_OP_JAL      6'h03
`define MIPS_OP_BEQ      6'h04
`define MIPS_OP_BNE      6'h05
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_ADDIU    6'h09
`define MIPS_OP_SLTI     6'h0a
`define MIPS_OP_SLTIU    6'h0b
`define MIPS_OP_ANDI     6'h0c
`define MIPS_OP_ORI      6'h0d
`define MIPS_OP_XORI     6'h0e
`define MIPS_OP_LUI      6'h0f
`define MIPS_OP_LB       6'h20
`define MIPS_OP_LH       6'h21
`define MIPS_OP_LW       6'h23
`define MIPS_OP_LBU      6'h24
`define MIPS_OP_LHU      6'h25
`define MIPS_OP_SB       6'h28
`define MIPS_OP_SH       6'h29
`define MIPS_OP_SW       6'h2b

// funct field of special ops
`define MIPS_FN_SLL      6'h00
`define MIPS_FN_SRL      6'h02
`define MIPS_FN_SRA      6'h03
`define MIPS_FN_SLLV     6'h04
`define MIPS_FN_SRLV     6'h06
`define MIPS_FN_SRAV     6'h07
`define MIPS_FN_JR       6'h08
`define MIPS_FN_JALR     6'h09
`define MIPS_FN_SYSCALL  6'h0c
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_ADDU     6'h21
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_SUBU     6'h23
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_XOR      6'h26
`define MIPS_FN_NOR      6'h27
`define MIPS_FN_SLT      6'h2a
`define MIPS_FN_SLTU     6'h2b

// alu select
`define MIPS_ALU_ADD     4'h0
`define MIPS_ALU_SUB     4'h1
`define MIPS_ALU_AND     4'h2
`define MIPS_ALU_OR      4'h3
`define MIPS_ALU_XOR     4'h4
`define MIPS_ALU_NOR     4'h5
`define MIPS_ALU_SLT     4'h6
`define MIPS_ALU_SLTU    4'h7
`define MIPS_ALU_SLL     4'h8
`define MIPS_ALU_SRL     4'h9
`define MIPS_ALU_SRA     4'ha

// load select, same as low opcode bits of the load (lui is 0f)
`define MIPS_LD_LB       3'd0
`define MIPS_LD_LH       3'd1
`define MIPS_LD_LW       3'd3
`define MIPS_LD_LBU      3'd4
`define MIPS_LD_LHU      3'd5
`define MIPS_LD_LUI      3'd7

`endif

// File: rtl/mips_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction word union and control enums
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "mips_cfg.svh"

package mips_pkg;

   typedef struct packed {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } instr_r_t;

   typedef struct packed {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;
   } instr_i_t;

   typedef struct packed {
      logic [5:0]  op;
      logic [25:0] target;
   } instr_j_t;

   // same 32 bits, three formats
   typedef union packed {
      instr_r_t r;
      instr_i_t i;
      instr_j_t j;
   } instr_t;

   typedef enum logic [3:0] {
      ALU_ADD  = `MIPS_ALU_ADD,
      ALU_SUB  = `MIPS_ALU_SUB,
      ALU_AND  = `MIPS_ALU_AND,
      ALU_OR   = `MIPS_ALU_OR,
      ALU_XOR  = `MIPS_ALU_XOR,
      ALU_NOR  = `MIPS_ALU_NOR,
      ALU_SLT  = `MIPS_ALU_SLT,
      ALU_SLTU = `MIPS_ALU_SLTU,
      ALU_SLL  = `MIPS_ALU_SLL,
      ALU_SRL  = `MIPS_ALU_SRL,
      ALU_SRA  = `MIPS_ALU_SRA
   } alu_sel_e;

   typedef enum logic [2:0] {
      LD_LB  = `MIPS_LD_LB,
      LD_LH  = `MIPS_LD_LH,
      LD_LW  = `MIPS_LD_LW,
      LD_LBU = `MIPS_LD_LBU,
      LD_LHU = `MIPS_LD_LHU,
      LD_LUI = `MIPS_LD_LUI   // upper immediate, no memory read
   } ld_sel_e;

   typedef enum logic [1:0] {ST_NONE, ST_BYTE, ST_HALF, ST_WORD} st_size_e;
   typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_REG, PC_JUMP} pc_sel_e;
   typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_LINK} wb_sel_e;

endpackage

// File: rtl/mips_fetch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pc and delay-slot next pc, branch and jump targets
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_fetch import mips_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic                  hold,      // halt, freeze both pcs
   input  pc_sel_e               pc_sel,
   input  logic                  branch_ne,
   input  logic                  is_branch,
   input  instr_t                inst,
   input  logic [`MIPS_XLEN-1:0] rs_data,
   input  logic [`MIPS_XLEN-1:0] rt_data,
   output logic [`MIPS_XLEN-1:0] pc
);

   logic [`MIPS_XLEN-1:0] npc_q;      // delay slot address
   logic [`MIPS_XLEN-1:0] seq_pc;     // pc+4
   logic [`MIPS_XLEN-1:0] npc_seq;
   logic [`MIPS_XLEN-1:0] br_target;
   logic [`MIPS_XLEN-1:0] jmp_target;
   logic [`MIPS_XLEN-1:0] target;
   logic                  taken;

   assign seq_pc  = pc + 32'd4;
   assign npc_seq = npc_q + 32'd4;
   // offset is in words, relative to the delay slot
   assign br_target  = seq_pc + {{(`MIPS_XLEN-18){inst.i.imm[15]}}, inst.i.imm, 2'b00};
   assign jmp_target = {seq_pc[31:28], inst.j.target, 2'b00};  // 256MB region
   assign taken = is_branch && ((rs_data == rt_data) != branch_ne);

   always_comb begin
      case (pc_sel)
         PC_BRANCH: target = taken ? br_target : npc_seq;
         PC_REG:    target = rs_data;     // jr, jalr
         PC_JUMP:   target = jmp_target;  // j, jal
         default:   target = npc_seq;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc    <= `MIPS_TEXT_START;
         npc_q <= `MIPS_TEXT_START + 32'd4;
      end else if (!hold) begin
         pc    <= npc_q;   // delay slot runs next
         npc_q <= target;
      end
   end

   // word fetch only, a bad jr target would break this
   pc_aligned: assert property (@(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00);

endmodule

// File: rtl/mips_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction decoder, control signals and reserved flag
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_decode import mips_pkg::*; (
   input  instr_t   inst,
   output alu_sel_e alu_sel,
   output logic     alu_src_imm,  // b operand is the immediate
   output logic     imm_signed,
   output logic     shift_var,    // shift amount from rs
   output logic     reg_we,
   output logic     reg_dst_rd,
   output wb_sel_e  wb_sel,
   output ld_sel_e  ld_sel,
   output st_size_e st_size,
   output pc_sel_e  pc_sel,
   output logic     is_branch,
   output logic     branch_ne,
   output logic     is_syscall,
   output logic     reserved
);

   always_comb begin
      alu_sel     = ALU_ADD;
      alu_src_imm = 1'b0;
      imm_signed  = 1'b1;
      shift_var   = 1'b0;
      reg_we      = 1'b0;
      reg_dst_rd  = 1'b0;
      wb_sel      = WB_ALU;
      ld_sel      = ld_sel_e'(inst.i.op[2:0]);  // codes track the opcode
      st_size     = ST_NONE;
      pc_sel      = PC_SEQ;
      is_branch   = 1'b0;
      branch_ne   = 1'b0;
      is_syscall  = 1'b0;
      reserved    = 1'b0;

      case (inst.i.op)
         `MIPS_OP_SPECIAL: begin
            reg_we     = 1'b1;
            reg_dst_rd = 1'b1;
            case (inst.r.funct)
               `MIPS_FN_ADD, `MIPS_FN_ADDU: alu_sel = ALU_ADD;  // no overflow trap
               `MIPS_FN_SUB, `MIPS_FN_SUBU: alu_sel = ALU_SUB;
               `MIPS_FN_AND:  alu_sel = ALU_AND;
               `MIPS_FN_OR:   alu_sel = ALU_OR;
               `MIPS_FN_XOR:  alu_sel = ALU_XOR;
               `MIPS_FN_NOR:  alu_sel = ALU_NOR;
               `MIPS_FN_SLT:  alu_sel = ALU_SLT;
               `MIPS_FN_SLTU: alu_sel = ALU_SLTU;
               `MIPS_FN_SLL:  alu_sel = ALU_SLL;
               `MIPS_FN_SRL:  alu_sel = ALU_SRL;
               `MIPS_FN_SRA:  alu_sel = ALU_SRA;
               `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV: begin
                  shift_var = 1'b1;
                  case (inst.r.funct[1:0])   // same low bits as sll/srl/sra
                     2'b10:   alu_sel = ALU_SRL;
                     2'b11:   alu_sel = ALU_SRA;
                     default: alu_sel = ALU_SLL;
                  endcase
               end
               `MIPS_FN_JR: begin
                  reg_we = 1'b0;
                  pc_sel = PC_REG;
               end
               `MIPS_FN_JALR: begin
                  pc_sel = PC_REG;
                  wb_sel = WB_LINK;   // link into rd
               end
               `MIPS_FN_SYSCALL: begin
                  reg_we     = 1'b0;
                  is_syscall = 1'b1;
               end
               default: reserved = 1'b1;
            endcase
         end
         `MIPS_OP_ADDI, `MIPS_OP_ADDIU, `MIPS_OP_SLTI, `MIPS_OP_SLTIU: begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            // sltiu compares unsigned, imm still sign extended
            case (inst.i.op[1:0])
               2'b10:   alu_sel = ALU_SLT;
               2'b11:   alu_sel = ALU_SLTU;
               default: alu_sel = ALU_ADD;
            endcase
         end
         `MIPS_OP_ANDI, `MIPS_OP_ORI, `MIPS_OP_XORI: begin
            alu_src_imm = 1'b1;
            imm_signed  = 1'b0;  // logic imms zero extend
            reg_we      = 1'b1;
            case (inst.i.op[1:0])
               2'b00:   alu_sel = ALU_AND;
               2'b01:   alu_sel = ALU_OR;
               default: alu_sel = ALU_XOR;
            endcase
         end
         `MIPS_OP_LUI, `MIPS_OP_LB, `MIPS_OP_LH, `MIPS_OP_LW,
         `MIPS_OP_LBU, `MIPS_OP_LHU: begin
            alu_src_imm = 1'b1;
            reg_we      = 1'b1;
            wb_sel      = WB_LOAD;
         end
         `MIPS_OP_SB, `MIPS_OP_SH, `MIPS_OP_SW: begin
            alu_src_imm = 1'b1;
            st_size     = inst.i.op[1] ? ST_WORD : (inst.i.op[0] ? ST_HALF : ST_BYTE);
         end
         `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
            pc_sel    = PC_BRANCH;
            is_branch = 1'b1;
            branch_ne = inst.i.op[0];
         end
         `MIPS_OP_J:   pc_sel = PC_JUMP;
         `MIPS_OP_JAL: begin
            pc_sel = PC_JUMP;
            reg_we = 1'b1;
            wb_sel = WB_LINK;    // rt slot replaced by $ra in core
         end
         default: reserved = 1'b1;
      endcase

      if (reserved) begin   // nothing retires
         reg_we  = 1'b0;
         st_size = ST_NONE;
      end
   end

   // a store never also writes a register
   always_comb begin
      we_excl: assert #0 (!(reg_we && (st_size != ST_NONE)));
   end

endmodule

// File: rtl/mips_regfile.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file, $zero hardwired
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_regfile (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic [4:0]            rs_addr,
   input  logic [4:0]            rt_addr,
   input  logic [4:0]            wr_addr,
   input  logic [`MIPS_XLEN-1:0] wr_data,
   input  logic                  we,
   output logic [`MIPS_XLEN-1:0] rs_data,
   output logic [`MIPS_XLEN-1:0] rt_data,
   output logic [`MIPS_XLEN-1:0] v0_data    // syscall code
);

   logic [`MIPS_XLEN-1:0] regs [31:1];  // no storage for $zero

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wr_addr != 5'd0)) begin
         regs[wr_addr] <= wr_data;
      end
   end

   assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];
   assign v0_data = regs[2];

   // writes to $zero are dropped, no read moves
   zero_reg: assert property (@(posedge clk) disable iff (!rst_b)
      (we && wr_addr == 5'd0) ##1 ($stable(rs_addr) && $stable(rt_addr)) |->
         $stable(rs_data) && $stable(rt_data));

endmodule

// File: rtl/mips_alu.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// alu, add/sub, logic, compare and shifts
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_alu import mips_pkg::*; (
   input  logic [`MIPS_XLEN-1:0] a,       // rs
   input  logic [`MIPS_XLEN-1:0] b,       // rt or immediate
   input  logic [4:0]            shamt,
   input  alu_sel_e              sel,
   output logic [`MIPS_XLEN-1:0] result
);

   always_comb begin
      case (sel)
         ALU_ADD:  result = a + b;
         ALU_SUB:  result = a - b;
         ALU_AND:  result = a & b;
         ALU_OR:   result = a | b;
         ALU_XOR:  result = a ^ b;
         ALU_NOR:  result = ~(a | b);
         ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
         ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
         // shifts move rt
         ALU_SLL:  result = b << shamt;
         ALU_SRL:  result = b >> shamt;
         ALU_SRA:  result = $unsigned($signed(b) >>> shamt);  // keep sign
         default:  result = a + b;
      endcase
   end

endmodule

// File: rtl/mips_mem_port.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store lane steering and masks, load extract and extend
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_mem_port import mips_pkg::*; (
   input  logic [1:0]            addr_low,
   input  st_size_e              st_size,
   input  ld_sel_e               ld_sel,
   input  logic [`MIPS_XLEN-1:0] rt_data,
   input  logic [15:0]           imm,
   input  logic [`MIPS_XLEN-1:0] mem_data_out,
   output logic [`MIPS_XLEN-1:0] mem_data_in,
   output logic [3:0]            mem_write_en,
   output logic [`MIPS_XLEN-1:0] load_data
);

   logic [7:0]  ld_byte;
   logic [15:0] ld_half;

   // little endian lanes, byte n at addr_low n
   always_comb begin
      case (st_size)
         ST_BYTE: begin
            mem_data_in  = {4{rt_data[7:0]}};
            mem_write_en = 4'b0001 << addr_low;
         end
         ST_HALF: begin
            mem_data_in  = {2{rt_data[15:0]}};
            mem_write_en = addr_low[1] ? 4'b1100 : 4'b0011;
         end
         ST_WORD: begin
            mem_data_in  = rt_data;
            mem_write_en = 4'b1111;
         end
         default: begin
            mem_data_in  = rt_data;
            mem_write_en = 4'b0000;   // not a store
         end
      endcase
   end

   assign ld_byte = mem_data_out[8*addr_low +: 8];
   assign ld_half = addr_low[1] ? mem_data_out[31:16] : mem_data_out[15:0];

   always_comb begin
      case (ld_sel)
         LD_LB:   load_data = {{24{ld_byte[7]}}, ld_byte};
         LD_LBU:  load_data = {24'h0, ld_byte};
         LD_LH:   load_data = {{16{ld_half[15]}}, ld_half};
         LD_LHU:  load_data = {16'h0, ld_half};
         LD_LUI:  load_data = {imm, 16'h0};
         default: load_data = mem_data_out;  // lw
      endcase
   end

   always_comb begin
      st_align: assert #0 ((st_size != ST_HALF || !addr_low[0]) &&
                           (st_size != ST_WORD || addr_low == 2'b00));
   end

endmodule

// File: rtl/mips_core.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single-cycle core top, operand and write-back muxes, halt
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_core import mips_pkg::*; (
   input  logic                  clk,
   input  logic                  rst_b,
   input  logic [31:0]           inst,
   input  logic                  inst_excpt,    // fetch error
   input  logic [`MIPS_XLEN-1:0] mem_data_out,
   output logic [29:0]           inst_addr,
   output logic [29:0]           mem_addr,
   output logic [`MIPS_XLEN-1:0] mem_data_in,
   output logic [3:0]            mem_write_en,
   output logic                  halted
);

   instr_t                ir;
   alu_sel_e              alu_sel;
   ld_sel_e               ld_sel;
   st_size_e              st_size;
   st_size_e              st_size_ok;    // gated by halt
   pc_sel_e               pc_sel;
   wb_sel_e               wb_sel;
   logic                  alu_src_imm, imm_signed, shift_var;
   logic                  reg_we, reg_dst_rd, is_branch, branch_ne;
   logic                  is_syscall, reserved;
   logic                  halt_now;
   logic                  commit;        // instruction may write state
   logic [`MIPS_XLEN-1:0] pc, rs_data, rt_data, v0_data;
   logic [`MIPS_XLEN-1:0] imm_ext, alu_b, alu_out, load_data, wr_data;
   logic [4:0]            wr_addr, shamt;

   assign ir = inst;
   assign inst_addr = pc[31:2];

   // syscall halts only with exit code in $v0
   assign halt_now   = inst_excpt || reserved || (is_syscall && v0_data == `MIPS_SYS_EXIT);
   assign commit     = !halted && !halt_now;
   assign st_size_ok = commit ? st_size : ST_NONE;

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         halted <= 1'b0;
      end else if (halt_now) begin
         halted <= 1'b1;   // sticky till reset
      end
   end

   mips_fetch u_fetch (
      .clk(clk), .rst_b(rst_b), .hold(!commit), .pc_sel(pc_sel), .branch_ne(branch_ne),
      .is_branch(is_branch), .inst(ir), .rs_data(rs_data), .rt_data(rt_data), .pc(pc)
   );

   mips_decode u_decode (
      .inst(ir), .alu_sel(alu_sel), .alu_src_imm(alu_src_imm), .imm_signed(imm_signed),
      .shift_var(shift_var), .reg_we(reg_we), .reg_dst_rd(reg_dst_rd), .wb_sel(wb_sel),
      .ld_sel(ld_sel), .st_size(st_size), .pc_sel(pc_sel), .is_branch(is_branch),
      .branch_ne(branch_ne), .is_syscall(is_syscall), .reserved(reserved)
   );

   // jal has no rd field, links to $ra
   assign wr_addr = reg_dst_rd ? ir.r.rd : ((wb_sel == WB_LINK) ? `MIPS_REG_RA : ir.r.rt);

   always_comb begin
      case (wb_sel)
         WB_LOAD: wr_data = load_data;
         WB_LINK: wr_data = pc + 32'd8;    // past the delay slot
         default: wr_data = alu_out;
      endcase
   end

   mips_regfile u_regfile (
      .clk(clk), .rst_b(rst_b), .rs_addr(ir.r.rs), .rt_addr(ir.r.rt), .wr_addr(wr_addr),
      .wr_data(wr_data), .we(reg_we && commit), .rs_data(rs_data), .rt_data(rt_data),
      .v0_data(v0_data)
   );

   assign imm_ext = imm_signed ? {{16{ir.i.imm[15]}}, ir.i.imm} : {16'h0, ir.i.imm};
   assign alu_b   = alu_src_imm ? imm_ext : rt_data;
   assign shamt   = shift_var ? rs_data[4:0] : ir.r.shamt;  // sllv etc take rs

   mips_alu u_alu (.a(rs_data), .b(alu_b), .shamt(shamt), .sel(alu_sel), .result(alu_out));

   assign mem_addr = alu_out[31:2];

   mips_mem_port u_mem_port (
      .addr_low(alu_out[1:0]), .st_size(st_size_ok), .ld_sel(ld_sel), .rt_data(rt_data),
      .imm(ir.i.imm), .mem_data_out(mem_data_out), .mem_data_in(mem_data_in),
      .mem_write_en(mem_write_en), .load_data(load_data)
   );

   no_wr_halted: assert property (@(posedge clk) disable iff (!rst_b)
      halted |-> mem_write_en == 4'b0000);

endmodule

// File: verification/mips_iss.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction-set model, one instruction per step
// own register file, data memory and delay-slot pc pair
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MIPS_ISS_SVH
`define MIPS_ISS_SVH

logic [31:0] m_regs [32];
logic [31:0] m_dmem [64];     // model copy of the data memory
logic [31:0] m_pc;
logic [31:0] m_npc;           // delay slot address
logic        m_halted;

task automatic iss_reset();
   for (int r = 0; r < 32; r++) begin
      m_regs[r] = '0;
   end
   m_pc     = `MIPS_TEXT_START;
   m_npc    = `MIPS_TEXT_START + 32'd4;
   m_halted = 1'b0;
endtask

// runs the word at m_pc, returns the store it should present
task automatic iss_step(input logic [31:0] w, input logic excpt, output logic [3:0] we,
                        output logic [29:0] addr, output logic [31:0] data);
   logic [5:0]  op;
   logic [5:0]  fn;
   logic [4:0]  rs, rt, rd, sh;
   logic [31:0] a, b, se, ze, ea, word, next, wval;
   logic [15:0] half;
   logic [7:0]  byt;
   logic [4:0]  wd;
   logic        wr, halt_i;
   op = w[31:26];
   rs = w[25:21];
   rt = w[20:16];
   rd = w[15:11];
   sh = w[10:6];
   fn = w[5:0];
   a = m_regs[rs];
   b = m_regs[rt];
   se = {{16{w[15]}}, w[15:0]};
   ze = {16'h0, w[15:0]};
   ea = a + se;                       // load/store address
   word = m_dmem[ea[7:2]];
   byt = word[8*ea[1:0] +: 8];
   half = ea[1] ? word[31:16] : word[15:0];
   next = m_npc + 32'd4;
   wr = 1'b1;
   wd = rt;                           // i-format default
   wval = '0;
   we = 4'b0000;
   addr = ea[31:2];
   data = '0;
   halt_i = excpt;
   case (op)
      `MIPS_OP_SPECIAL: begin
         wd = rd;
         case (fn)
            `MIPS_FN_ADD, `MIPS_FN_ADDU: wval = a + b;
            `MIPS_FN_SUB, `MIPS_FN_SUBU: wval = a - b;
            `MIPS_FN_AND:  wval = a & b;
            `MIPS_FN_OR:   wval = a | b;
            `MIPS_FN_XOR:  wval = a ^ b;
            `MIPS_FN_NOR:  wval = ~(a | b);
            `MIPS_FN_SLT:  wval = {31'h0, $signed(a) < $signed(b)};
            `MIPS_FN_SLTU: wval = {31'h0, a < b};
            `MIPS_FN_SLL:  wval = b << sh;
            `MIPS_FN_SRL:  wval = b >> sh;
            `MIPS_FN_SRA:  wval = $signed(b) >>> sh;
            `MIPS_FN_SLLV: wval = b << a[4:0];
            `MIPS_FN_SRLV: wval = b >> a[4:0];
            `MIPS_FN_SRAV: wval = $signed(b) >>> a[4:0];
            `MIPS_FN_JR: begin
               wr = 1'b0;
               next = a;
            end
            `MIPS_FN_JALR: begin
               wval = m_pc + 32'd8;   // return past the delay slot
               next = a;
            end
            `MIPS_FN_SYSCALL: begin
               wr = 1'b0;
               if (m_regs[2] == `MIPS_SYS_EXIT) halt_i = 1'b1;
            end
            default: halt_i = 1'b1;   // reserved funct
         endcase
      end
      `MIPS_OP_ADDI, `MIPS_OP_ADDIU: wval = a + se;
      `MIPS_OP_SLTI:  wval = {31'h0, $signed(a) < $signed(se)};
      `MIPS_OP_SLTIU: wval = {31'h0, a < se};
      `MIPS_OP_ANDI:  wval = a & ze;
      `MIPS_OP_ORI:   wval = a | ze;
      `MIPS_OP_XORI:  wval = a ^ ze;
      `MIPS_OP_LUI:   wval = {w[15:0], 16'h0};
      `MIPS_OP_LB:    wval = {{24{byt[7]}}, byt};
      `MIPS_OP_LBU:   wval = {24'h0, byt};
      `MIPS_OP_LH:    wval = {{16{half[15]}}, half};
      `MIPS_OP_LHU:   wval = {16'h0, half};
      `MIPS_OP_LW:    wval = word;
      `MIPS_OP_SB: begin
         wr = 1'b0;
         we = 4'b0001 << ea[1:0];
         data = {4{b[7:0]}};
      end
      `MIPS_OP_SH: begin
         wr = 1'b0;
         we = ea[1] ? 4'b1100 : 4'b0011;
         data = {2{b[15:0]}};
      end
      `MIPS_OP_SW: begin
         wr = 1'b0;
         we = 4'b1111;
         data = b;
      end
      `MIPS_OP_BEQ, `MIPS_OP_BNE: begin
         wr = 1'b0;
         if ((a == b) != op[0]) next = m_pc + 32'd4 + {se[29:0], 2'b00};
      end
      `MIPS_OP_J, `MIPS_OP_JAL: begin
         wr = op[0];                  // jal only
         wd = `MIPS_REG_RA;
         wval = m_pc + 32'd8;
         next = {m_pc[31:28] + 4'h0, w[25:0], 2'b00};
      end
      default: halt_i = 1'b1;
   endcase
   if (m_halted || halt_i) begin
      we = 4'b0000;                   // faulting cycle writes nothing
      m_halted = 1'b1;
   end else begin
      for (int i = 0; i < 4; i++) begin
         if (we[i]) m_dmem[ea[7:2]][8*i +: 8] = data[8*i +: 8];
      end
      if (wr && wd != 5'd0) m_regs[wd] = wval;
      m_pc = m_npc;
      m_npc = next;
   end
endtask

`endif

// File: verification/mips_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core testbench, random program generator, memories
// per-cycle compare against the iss model, watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "mips_cfg.svh"

module mips_tb;

   localparam int PROG_WORDS = 256;
   localparam int RUNS       = 3;     // normal, reserved word, fetch error
   localparam int LIMIT_NS   = RUNS * (PROG_WORDS + 20 + 10) * 40;

   logic        clk, rst_b, inst_excpt, halted;
   logic [31:0] inst, mem_data_out, mem_data_in;
   logic [29:0] inst_addr, mem_addr;
   logic [3:0]  mem_write_en;
   logic [31:0] imem [PROG_WORDS];
   logic [31:0] dmem [64];
   logic [31:0] lfsr;
   logic [5:0]  rop_fn [16];
   int          errors, checks, idx;

   `include "mips_iss.svh"

   mips_core u_mips_core (
      .clk(clk), .rst_b(rst_b), .inst(inst), .inst_excpt(inst_excpt),
      .mem_data_out(mem_data_out), .inst_addr(inst_addr), .mem_addr(mem_addr),
      .mem_data_in(mem_data_in), .mem_write_en(mem_write_en), .halted(halted)
   );

   // text base has zero low word bits
   assign inst         = imem[inst_addr[7:0]];
   assign mem_data_out = dmem[mem_addr[5:0]];

   always @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (mem_write_en[i]) dmem[mem_addr[5:0]][8*i +: 8] <= mem_data_in[8*i +: 8];
      end
   end

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // galois lfsr, one step per bit
   function automatic logic [31:0] rnd(int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [31:0] i_word(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] r_word(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                          logic [4:0] sh, logic [5:0] fn);
      return {`MIPS_OP_SPECIAL, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [4:0] pick_dst();
      return 5'd3 + 5'(rnd(5) % 22);   // $3..$24, $v0 and $25 kept clear
   endfunction

   function automatic logic [31:0] mask_bytes(logic [3:0] we);
      return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
   endfunction

   task automatic put(logic [31:0] w);
      imem[idx] = w;
      idx++;
   endtask

   task automatic put_rop(logic [4:0] d);
      put(r_word(rnd(5), rnd(5), d, rnd(5), rop_fn[rnd(4)]));
   endtask

   task automatic check(string name, logic [31:0] act, logic [31:0] exp);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("error: t=%0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic gen_program();
      logic [5:0]  op;
      logic [4:0]  d, s;
      logic [31:0] off, tidx;
      logic        link;
      idx = 0;
      for (int r = 3; r < 25; r++) begin   // seed the registers
         put(i_word(`MIPS_OP_LUI, 0, r, rnd(16)));
         put(i_word(`MIPS_OP_ORI, r, r, rnd(16)));
      end
      while (idx < 200) begin
         d = pick_dst();
         off = 1 + rnd(1);
         link = rnd(1);
         case (rnd(3))
            0: begin
               put_rop(d);
               put(i_word(`MIPS_OP_SW, 0, d, rnd(6) << 2));
            end
            1: begin
               case (rnd(3) % 7)
                  0: op = `MIPS_OP_ADDI;
                  1: op = `MIPS_OP_ADDIU;
                  2: op = `MIPS_OP_SLTI;
                  3: op = `MIPS_OP_SLTIU;
                  4: op = `MIPS_OP_ANDI;
                  5: op = `MIPS_OP_ORI;
                  default: op = `MIPS_OP_XORI;
               endcase
               put(i_word(op, rnd(5), d, rnd(16)));
               put(i_word(`MIPS_OP_SW, 0, d, rnd(6) << 2));
            end
            2: begin
               case (rnd(3) % 6)
                  0: put(i_word(`MIPS_OP_LB, 0, d, rnd(8)));
                  1: put(i_word(`MIPS_OP_LBU, 0, d, rnd(8)));
                  2: put(i_word(`MIPS_OP_LH, 0, d, rnd(7) << 1));
                  3: put(i_word(`MIPS_OP_LHU, 0, d, rnd(7) << 1));
                  4: put(i_word(`MIPS_OP_LW, 0, d, rnd(6) << 2));
                  default: put(i_word(`MIPS_OP_LUI, 0, d, rnd(16)));
               endcase
               put(i_word(`MIPS_OP_SW, 0, d, rnd(6) << 2));
            end
            3: begin
               case (rnd(2))
                  0: put(i_word(`MIPS_OP_SB, 0, rnd(5), rnd(8)));
                  1: put(i_word(`MIPS_OP_SH, 0, rnd(5), rnd(7) << 1));
                  default: put(i_word(`MIPS_OP_SW, 0, rnd(5), rnd(6) << 2));
               endcase
            end
            4: begin
               s = rnd(5);
               put(i_word(link ? `MIPS_OP_BNE : `MIPS_OP_BEQ, s, rnd(1) ? s : rnd(5), off));
               repeat (off) put_rop(d);       // delay slot, then skipped words
            end
            5: begin
               tidx = idx + 1 + off;
               put({link ? `MIPS_OP_JAL : `MIPS_OP_J, 26'((`MIPS_TEXT_START >> 2) + tidx)});
               repeat (off) put_rop(d);
               if (link) put(i_word(`MIPS_OP_SW, 0, `MIPS_REG_RA, rnd(6) << 2));
            end
            6: begin
               tidx = idx + 3 + off;
               put(i_word(`MIPS_OP_LUI, 0, 25, `MIPS_TEXT_START >> 16));
               put(i_word(`MIPS_OP_ORI, 25, 25, tidx << 2));
               put(r_word(25, 0, link ? d : 5'd0, 0, link ? `MIPS_FN_JALR : `MIPS_FN_JR));
               repeat (off) put_rop(pick_dst());
               if (link) put(i_word(`MIPS_OP_SW, 0, d, rnd(6) << 2));
            end
            default: begin
               put(i_word(`MIPS_OP_ADDIU, 0, 2, rnd(3)));   // 0..7, no exit
               put(r_word(0, 0, 0, 0, `MIPS_FN_SYSCALL));
            end
         endcase
      end
      put(i_word(`MIPS_OP_ADDIU, 0, 2, `MIPS_SYS_EXIT));
      put(r_word(0, 0, 0, 0, `MIPS_FN_SYSCALL));
      while (idx < PROG_WORDS) put(rnd(1) ? {6'h3f, 26'(rnd(26))} : rnd(32));
   endtask

   task automatic run_one(int mode);
      logic [3:0]  e_we;
      logic [29:0] e_addr;
      logic [31:0] e_data;
      int          cyc, hold_cnt;
      gen_program();
      for (int i = 0; i < 64; i++) begin
         dmem[i] = rnd(32);
         m_dmem[i] = dmem[i];
      end
      iss_reset();
      rst_b = 1'b0;
      inst_excpt = 1'b0;
      repeat (5) @(posedge clk);
      #2 rst_b = 1'b1;
      cyc = 0;
      hold_cnt = 0;
      while (hold_cnt < 4) begin
         @(negedge clk);
         check("inst_addr", inst_addr, m_pc[31:2]);
         check("halted", halted, m_halted);
         iss_step(imem[m_pc[9:2]], inst_excpt, e_we, e_addr, e_data);
         check("mem_write_en", mem_write_en, e_we);
         if (e_we != 4'b0000) begin
            check("mem_addr", mem_addr, e_addr);
            check("mem_data_in", mem_data_in & mask_bytes(e_we), e_data & mask_bytes(e_we));
         end
         if (m_halted) hold_cnt++;
         @(posedge clk);
         #2;
         cyc++;
         inst_excpt = (mode == 2) && (cyc == 90);   // one faulting fetch
         // reserved opcode on the word fetched this cycle
         if (mode == 1 && cyc == 90) imem[m_pc[9:2]] = {6'h3f, 26'h0};
      end
   endtask

   initial begin
      #(LIMIT_NS);
      $display("timeout: the core never finished its programs");
      $display("test failed");
      $finish;
   end

   initial begin
      rst_b = 1'b0;
      inst_excpt = 1'b0;
      lfsr = 32'hf197fab6;
      errors = 0;
      checks = 0;
      rop_fn = '{`MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA, `MIPS_FN_SLLV, `MIPS_FN_SRLV,
                 `MIPS_FN_SRAV, `MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
                 `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR, `MIPS_FN_SLT,
                 `MIPS_FN_SLTU};
      for (int m = 0; m < RUNS; m++) begin
         run_one(m);
      end
      $display("summary: %0d errors in %0d checks over %0d runs", errors, checks, RUNS);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+rtl
+incdir+verification
rtl/mips_pkg.sv
rtl/mips_fetch.sv
rtl/mips_decode.sv
rtl/mips_regfile.sv
rtl/mips_alu.sv
rtl/mips_mem_port.sv
rtl/mips_core.sv
verification/mips_tb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mips_pkg.sv
      - rtl/mips_fetch.sv
      - rtl/mips_decode.sv
      - rtl/mips_regfile.sv
      - rtl/mips_alu.sv
      - rtl/mips_mem_port.sv
      - rtl/mips_core.sv
  - target: simulation
    include_dirs:
      - rtl
      - verification
    files:
      - verification/mips_tb.sv
